// ==== rtl/lc3b_types.sv ====
`default_nettype none

package lc3b_types;

    typedef logic [15:0] lc3b_word;

    // opcodes of the supported subset
    localparam logic [3:0] op_br  = 4'b0000;
    localparam logic [3:0] op_add = 4'b0001;
    localparam logic [3:0] op_and = 4'b0101;
    localparam logic [3:0] op_ldr = 4'b0110;
    localparam logic [3:0] op_str = 4'b0111;
    localparam logic [3:0] op_not = 4'b1001;
    localparam logic [3:0] op_shf = 4'b1101;

    // one instruction word seen through each format
    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            logic [2:0] dr;
            logic [2:0] sr1;
            logic       imm;      // set selects imm5
            logic [4:0] sr2_imm5; // sr2 sits in the low three bits
        } opr;
        struct packed {
            logic [3:0] opcode;
            logic [2:0] dr;
            logic [2:0] sr1;
            logic       arith;    // right shifts only
            logic       dir;      // 0 shifts left
            logic [3:0] imm4;
        } shf;
        struct packed {
            logic [3:0] opcode;
            logic [2:0] dr_sr;    // load dest or store source
            logic [2:0] base;
            logic [5:0] offset6;
        } mem;
        struct packed {
            logic [3:0] opcode;
            logic       n;
            logic       z;
            logic       p;
            logic [8:0] offset9;
        } br;
    } lc3b_instr;

endpackage

`default_nettype wire

// ==== rtl/lc3b_ctrl_pkg.sv ====
`default_nettype none

package lc3b_ctrl_pkg;

    localparam int ctrl_width = 12;

    // control word bit positions
    localparam int ctrl_branch        = 0;  // used in mem
    localparam int ctrl_sr2_sel       = 1;  // decode reads the store source
    localparam int ctrl_alu_b_sel_lsb = 2;
    localparam int ctrl_alu_b_sel_msb = 3;
    localparam int ctrl_alu_op_lsb    = 4;
    localparam int ctrl_alu_op_msb    = 6;
    localparam int ctrl_cc_load       = 7;
    localparam int ctrl_cc_sel        = 8;  // set takes mdr
    localparam int ctrl_mem_write     = 9;
    localparam int ctrl_wb_sel        = 10; // set takes mdr
    localparam int ctrl_regfile_load  = 11;

    // alu operand b sources
    localparam logic [1:0] alu_b_sr2   = 2'd0;
    localparam logic [1:0] alu_b_imm5  = 2'd1;
    localparam logic [1:0] alu_b_imm4  = 2'd2;
    localparam logic [1:0] alu_b_off6w = 2'd3; // offset6 scaled to words

    // alu operations
    localparam logic [2:0] alu_add  = 3'd0;
    localparam logic [2:0] alu_and  = 3'd1;
    localparam logic [2:0] alu_not  = 3'd2;
    localparam logic [2:0] alu_sll  = 3'd3;
    localparam logic [2:0] alu_srl  = 3'd4;
    localparam logic [2:0] alu_sra  = 3'd5;
    localparam logic [2:0] alu_pass = 3'd6;

endpackage

`default_nettype wire

// ==== rtl/control_rom.sv ====
`default_nettype none

module control_rom (
    input  wire lc3b_types::lc3b_word            ir_in,
    output logic [lc3b_ctrl_pkg::ctrl_width-1:0] control_out
);

    lc3b_types::lc3b_instr ir;

    logic       branch;
    logic       sr2_sel;
    logic [1:0] alu_b_sel;
    logic [2:0] alu_op;
    logic       cc_load;
    logic       cc_sel;
    logic       mem_write;
    logic       wb_sel;
    logic       regfile_load;

    assign ir = ir_in;

    always_comb begin
        // defaults, then per opcode
        branch       = 1'b0;
        sr2_sel      = 1'b0;
        alu_b_sel    = lc3b_ctrl_pkg::alu_b_sr2;
        alu_op       = lc3b_ctrl_pkg::alu_pass;
        cc_load      = 1'b0;
        cc_sel       = 1'b0;
        mem_write    = 1'b0;
        wb_sel       = 1'b0;
        regfile_load = 1'b0;

        case (ir.opr.opcode)
            lc3b_types::op_add, lc3b_types::op_and: begin
                if (ir.opr.imm) begin
                    alu_b_sel = lc3b_ctrl_pkg::alu_b_imm5;
                end
                alu_op = (ir.opr.opcode == lc3b_types::op_add) ?
                         lc3b_ctrl_pkg::alu_add : lc3b_ctrl_pkg::alu_and;
                cc_load      = 1'b1;
                regfile_load = 1'b1;
            end
            lc3b_types::op_not: begin
                alu_op       = lc3b_ctrl_pkg::alu_not;
                cc_load      = 1'b1;
                regfile_load = 1'b1;
            end
            lc3b_types::op_shf: begin
                alu_b_sel = lc3b_ctrl_pkg::alu_b_imm4;
                if (!ir.shf.dir) begin
                    alu_op = lc3b_ctrl_pkg::alu_sll;
                end else if (!ir.shf.arith) begin
                    alu_op = lc3b_ctrl_pkg::alu_srl;
                end else begin
                    alu_op = lc3b_ctrl_pkg::alu_sra;
                end
                cc_load      = 1'b1;
                regfile_load = 1'b1;
            end
            lc3b_types::op_ldr: begin
                alu_b_sel    = lc3b_ctrl_pkg::alu_b_off6w; // base + offset
                alu_op       = lc3b_ctrl_pkg::alu_add;
                cc_load      = 1'b1;
                cc_sel       = 1'b1; // codes from loaded word
                wb_sel       = 1'b1;
                regfile_load = 1'b1;
            end
            lc3b_types::op_str: begin
                sr2_sel   = 1'b1; // store data comes from dr_sr
                alu_b_sel = lc3b_ctrl_pkg::alu_b_off6w;
                alu_op    = lc3b_ctrl_pkg::alu_add;
                mem_write = 1'b1;
            end
            lc3b_types::op_br: begin
                branch = 1'b1;
            end
            default: begin
                alu_op = '0; // unknown opcode becomes a bubble
            end
        endcase
    end

    always_comb begin
        control_out[lc3b_ctrl_pkg::ctrl_branch]       = branch;
        control_out[lc3b_ctrl_pkg::ctrl_sr2_sel]      = sr2_sel;
        control_out[lc3b_ctrl_pkg::ctrl_alu_b_sel_msb:
                    lc3b_ctrl_pkg::ctrl_alu_b_sel_lsb] = alu_b_sel;
        control_out[lc3b_ctrl_pkg::ctrl_alu_op_msb:
                    lc3b_ctrl_pkg::ctrl_alu_op_lsb]    = alu_op;
        control_out[lc3b_ctrl_pkg::ctrl_cc_load]      = cc_load;
        control_out[lc3b_ctrl_pkg::ctrl_cc_sel]       = cc_sel;
        control_out[lc3b_ctrl_pkg::ctrl_mem_write]    = mem_write;
        control_out[lc3b_ctrl_pkg::ctrl_wb_sel]       = wb_sel;
        control_out[lc3b_ctrl_pkg::ctrl_regfile_load] = regfile_load;
    end

endmodule

`default_nettype wire

// ==== rtl/regfile.sv ====
`default_nettype none

module regfile (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       load,
    input  wire [2:0]                 dest,
    input  wire lc3b_types::lc3b_word in,
    input  wire [2:0]                 src_a,
    input  wire [2:0]                 src_b,
    output lc3b_types::lc3b_word      reg_a,
    output lc3b_types::lc3b_word      reg_b
);

    lc3b_types::lc3b_word regs [8];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (load) begin
            regs[dest] <= in;
        end
    end

    // write-through so decode sees this cycle's writeback
    assign reg_a = (load && dest == src_a) ? in : regs[src_a];
    assign reg_b = (load && dest == src_b) ? in : regs[src_b];

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`default_nettype none

module alu (
    input  wire [2:0]                 aluop,
    input  wire lc3b_types::lc3b_word a,
    input  wire lc3b_types::lc3b_word b,
    output lc3b_types::lc3b_word      f
);

    logic [3:0] shamt;

    assign shamt = b[3:0]; // shifts only look at imm4

    always_comb begin
        case (aluop)
            lc3b_ctrl_pkg::alu_add:  f = a + b;
            lc3b_ctrl_pkg::alu_and:  f = a & b;
            lc3b_ctrl_pkg::alu_not:  f = ~a;
            lc3b_ctrl_pkg::alu_sll:  f = a << shamt;
            lc3b_ctrl_pkg::alu_srl:  f = a >> shamt;
            lc3b_ctrl_pkg::alu_sra: begin
                f = lc3b_types::lc3b_word'($signed(a) >>> shamt);
            end
            lc3b_ctrl_pkg::alu_pass: f = b;
            default:                 f = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/data_memory.sv ====
`default_nettype none

module data_memory (
    input  wire                       clk,
    input  wire                       write,
    input  wire [7:0]                 addr,   // word index
    input  wire lc3b_types::lc3b_word wdata,
    output lc3b_types::lc3b_word      rdata
);

    lc3b_types::lc3b_word mem [256];

    always_ff @(posedge clk) begin
        if (write) begin
            mem[addr] <= wdata;
        end
    end

    // loads read in the same cycle
    assign rdata = mem[addr];

endmodule

`default_nettype wire

// ==== rtl/lc3b_pipeline.sv ====
`default_nettype none

module lc3b_pipeline (
    input  wire                       clk,
    input  wire                       rst_n,
    output lc3b_types::lc3b_word      imem_addr,
    input  wire lc3b_types::lc3b_word imem_rdata,
    output logic                      wb_load,
    output logic [2:0]                wb_dest,
    output lc3b_types::lc3b_word      wb_data
);

    // fetch
    lc3b_types::lc3b_word pc;
    lc3b_types::lc3b_word pc_plus2;

    // decode
    lc3b_types::lc3b_instr                id_ir;
    lc3b_types::lc3b_word                 id_pc2;
    logic [lc3b_ctrl_pkg::ctrl_width-1:0] id_ctrl;
    logic [2:0]                           id_sr2_idx;
    lc3b_types::lc3b_word                 id_sr1_val;
    lc3b_types::lc3b_word                 id_sr2_val;

    // execute
    logic [lc3b_ctrl_pkg::ctrl_width-1:0] ex_ctrl;
    lc3b_types::lc3b_instr                ex_ir;
    lc3b_types::lc3b_word                 ex_pc2;
    lc3b_types::lc3b_word                 ex_sr1_val;
    lc3b_types::lc3b_word                 ex_sr2_val;
    logic [1:0]                           ex_alu_b_sel;
    logic [2:0]                           ex_alu_op;
    lc3b_types::lc3b_word                 ex_alu_b;
    lc3b_types::lc3b_word                 ex_alu_out;
    lc3b_types::lc3b_word                 ex_target;

    // memory
    logic [lc3b_ctrl_pkg::ctrl_width-1:0] mem_ctrl;
    lc3b_types::lc3b_word                 mem_alu;
    lc3b_types::lc3b_word                 mem_store;
    lc3b_types::lc3b_word                 mem_target;
    logic [2:0]                           mem_nzp;
    logic [2:0]                           mem_dest;
    lc3b_types::lc3b_word                 mem_rdata;
    lc3b_types::lc3b_word                 cc_in;
    logic [2:0]                           cc_next;
    logic [2:0]                           cc;      // n z p
    logic                                 br_en;

    // writeback
    logic [lc3b_ctrl_pkg::ctrl_width-1:0] wb_ctrl;
    lc3b_types::lc3b_word                 wb_alu;
    lc3b_types::lc3b_word                 wb_mdr;

    assign pc_plus2  = pc + 16'd2;
    assign imem_addr = pc;

    control_rom u_control_rom (
        .ir_in       (id_ir),
        .control_out (id_ctrl)
    );

    // stores read their data register through the second port
    assign id_sr2_idx = id_ctrl[lc3b_ctrl_pkg::ctrl_sr2_sel] ? id_ir.mem.dr_sr
                                                             : id_ir.opr.sr2_imm5[2:0];

    regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (wb_load),
        .dest  (wb_dest),
        .in    (wb_data),
        .src_a (id_ir.opr.sr1),
        .src_b (id_sr2_idx),
        .reg_a (id_sr1_val),
        .reg_b (id_sr2_val)
    );

    assign ex_alu_b_sel = ex_ctrl[lc3b_ctrl_pkg::ctrl_alu_b_sel_msb:
                                  lc3b_ctrl_pkg::ctrl_alu_b_sel_lsb];
    assign ex_alu_op    = ex_ctrl[lc3b_ctrl_pkg::ctrl_alu_op_msb:
                                  lc3b_ctrl_pkg::ctrl_alu_op_lsb];

    always_comb begin
        case (ex_alu_b_sel)
            lc3b_ctrl_pkg::alu_b_imm5: begin
                ex_alu_b = {{11{ex_ir.opr.sr2_imm5[4]}}, ex_ir.opr.sr2_imm5};
            end
            lc3b_ctrl_pkg::alu_b_imm4: begin
                ex_alu_b = {12'b0, ex_ir.shf.imm4};
            end
            lc3b_ctrl_pkg::alu_b_off6w: begin
                ex_alu_b = {{9{ex_ir.mem.offset6[5]}}, ex_ir.mem.offset6, 1'b0};
            end
            default: ex_alu_b = ex_sr2_val;
        endcase
    end

    alu u_alu (
        .aluop (ex_alu_op),
        .a     (ex_sr1_val),
        .b     (ex_alu_b),
        .f     (ex_alu_out)
    );

    // branch target relative to the next pc
    assign ex_target = ex_pc2 + {{6{ex_ir.br.offset9[8]}}, ex_ir.br.offset9, 1'b0};

    data_memory u_data_memory (
        .clk   (clk),
        .write (mem_ctrl[lc3b_ctrl_pkg::ctrl_mem_write]),
        .addr  (mem_alu[8:1]),
        .wdata (mem_store),
        .rdata (mem_rdata)
    );

    assign cc_in   = mem_ctrl[lc3b_ctrl_pkg::ctrl_cc_sel] ? mem_rdata : mem_alu;
    assign cc_next = {cc_in[15], cc_in == '0, !cc_in[15] && cc_in != '0};
    assign br_en   = mem_ctrl[lc3b_ctrl_pkg::ctrl_branch] && |(mem_nzp & cc);

    assign wb_load = wb_ctrl[lc3b_ctrl_pkg::ctrl_regfile_load];
    assign wb_data = wb_ctrl[lc3b_ctrl_pkg::ctrl_wb_sel] ? wb_mdr : wb_alu;

    // pc, instruction and control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= '0;
            id_ir    <= '0;
            ex_ctrl  <= '0;
            mem_ctrl <= '0;
            wb_ctrl  <= '0;
            cc       <= 3'b010;
        end else begin
            pc       <= br_en ? mem_target : pc_plus2;
            id_ir    <= imem_rdata;
            ex_ctrl  <= id_ctrl;
            mem_ctrl <= ex_ctrl;
            wb_ctrl  <= mem_ctrl;
            if (mem_ctrl[lc3b_ctrl_pkg::ctrl_cc_load]) begin
                cc <= cc_next;
            end
        end
    end

    // datapath stage registers
    always_ff @(posedge clk) begin
        id_pc2     <= pc_plus2;

        ex_ir      <= id_ir;
        ex_pc2     <= id_pc2;
        ex_sr1_val <= id_sr1_val;
        ex_sr2_val <= id_sr2_val;

        mem_alu    <= ex_alu_out;
        mem_store  <= ex_sr2_val;
        mem_target <= ex_target;
        mem_nzp    <= {ex_ir.br.n, ex_ir.br.z, ex_ir.br.p};
        mem_dest   <= ex_ir.opr.dr;

        wb_alu     <= mem_alu;
        wb_mdr     <= mem_rdata;
        wb_dest    <= mem_dest;
    end

endmodule

`default_nettype wire

// ==== tb/lc3b_pipeline_checker.sv ====
`default_nettype none

module lc3b_pipeline_checker (
    input wire                       clk,
    input wire                       rst_n,
    input wire lc3b_types::lc3b_word imem_addr,
    input wire                       br_en,
    input wire                       wb_load,
    input wire [2:0]                 wb_dest,
    input wire lc3b_types::lc3b_word wb_data
);

    // covers reset itself and the first cycle after release
    a_no_wb_in_reset: assert property (@(posedge clk) $past(!rst_n) |-> !wb_load)
        else $error("writeback during or right after reset");

    a_pc_even: assert property (@(posedge clk) disable iff (!rst_n) !imem_addr[0])
        else $error("odd fetch address");

    a_pc_step: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) && !$past(br_en) |-> imem_addr == $past(imem_addr) + 16'd2)
        else $error("fetch address did not advance by two");

    a_wb_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(wb_load) && (!wb_load || !$isunknown({wb_dest, wb_data})))
        else $error("unknown value on writeback port");

endmodule

`default_nettype wire

// ==== tb/lc3b_pipeline_tb.sv ====
`default_nettype none

module lc3b_pipeline_tb;

    localparam int prog_size = 512;
    localparam int max_steps = 600;
    localparam int watchdog_cycles = 6 * (10 + max_steps + 10) + 100;

    logic                 clk;
    logic                 rst_n;
    lc3b_types::lc3b_word imem_addr;
    lc3b_types::lc3b_word imem_rdata;
    logic                 wb_load;
    logic [2:0]           wb_dest;
    lc3b_types::lc3b_word wb_data;

    lc3b_types::lc3b_word prog [prog_size];
    int                   prog_len;
    lc3b_types::lc3b_word m_regs [8];   // reference model state
    logic [2:0]           m_cc;
    lc3b_types::lc3b_word m_mem [256];
    lc3b_types::lc3b_word exp_pc [max_steps]; // fetch address of each step
    logic [2:0]           exp_dest [$];
    lc3b_types::lc3b_word exp_data [$];
    int unsigned          lcg_state;
    int                   run_steps;

    lc3b_pipeline u_lc3b_pipeline (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .wb_load    (wb_load),
        .wb_dest    (wb_dest),
        .wb_data    (wb_data)
    );

    bind lc3b_pipeline lc3b_pipeline_checker u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .br_en     (br_en),
        .wb_load   (wb_load),
        .wb_dest   (wb_dest),
        .wb_data   (wb_data)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // instruction memory answers shortly after each edge
    always @(posedge clk) begin
        #1;
        imem_rdata = prog[imem_addr[9:1]];
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic cmp_word(input string name, input lc3b_types::lc3b_word got,
                            input lc3b_types::lc3b_word exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic cmp_dest(input string name, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
        end
    endtask

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 1103515245 + 12345;
        return (lcg_state >> 16) & 32'h7fff;
    endfunction

    function automatic lc3b_types::lc3b_word enc_opr(input logic [3:0] op, input int dr,
                                                     input int sr1, input logic imm,
                                                     input int low5);
        return {op, 3'(dr), 3'(sr1), imm, 5'(low5)};
    endfunction

    function automatic lc3b_types::lc3b_word enc_shf(input int dr, input int sr1,
                                                     input logic arith, input logic dir,
                                                     input int amt);
        return {lc3b_types::op_shf, 3'(dr), 3'(sr1), arith, dir, 4'(amt)};
    endfunction

    function automatic lc3b_types::lc3b_word enc_mem(input logic [3:0] op, input int r,
                                                     input int base, input int off);
        return {op, 3'(r), 3'(base), 6'(off)};
    endfunction

    function automatic lc3b_types::lc3b_word enc_br(input logic [2:0] nzp, input int off);
        return {lc3b_types::op_br, nzp, 9'(off)};
    endfunction

    function automatic logic [2:0] nzp_of(input lc3b_types::lc3b_word v);
        if (v == 16'd0) begin
            return 3'b010;
        end else if (v[15]) begin
            return 3'b100;
        end
        return 3'b001;
    endfunction

    function automatic lc3b_types::lc3b_word shift_right_arith(input lc3b_types::lc3b_word v,
                                                               input logic [3:0] n);
        lc3b_types::lc3b_word r;
        r = v;
        for (int i = 0; i < int'(n); i++) begin
            r = {r[15], r[15:1]}; // sign bit refills from the left
        end
        return r;
    endfunction

    task automatic clear_prog();
        for (int i = 0; i < prog_size; i++) begin
            prog[i] = '0; // nop fill
        end
        prog_len = 0;
    endtask

    // two nops after each word keep producers three apart
    task automatic emit(input lc3b_types::lc3b_word w);
        prog[prog_len]     = w;
        prog[prog_len + 1] = '0;
        prog[prog_len + 2] = '0;
        prog_len += 3;
    endtask

    task automatic model_write(input logic [2:0] dr, input lc3b_types::lc3b_word r);
        m_regs[dr] = r;
        m_cc = nzp_of(r);
        exp_dest.push_back(dr);
        exp_data.push_back(r);
    endtask

    // walks the fetch stream, branches redirect the fourth fetch after them
    task automatic build_expect();
        lc3b_types::lc3b_word  pc;
        lc3b_types::lc3b_word  a;
        lc3b_types::lc3b_word  b;
        lc3b_types::lc3b_word  r;
        lc3b_types::lc3b_word  addr;
        lc3b_types::lc3b_instr u;
        logic                  redir_v [max_steps + 8];
        lc3b_types::lc3b_word  redir_t [max_steps + 8];
        int                    last_redir;
        for (int i = 0; i < max_steps + 8; i++) begin
            redir_v[i] = 1'b0;
        end
        pc = '0;
        last_redir = -1;
        run_steps = 0;
        while (run_steps < max_steps &&
               (int'(pc[15:1]) < prog_len || run_steps <= last_redir)) begin
            if (redir_v[run_steps]) pc = redir_t[run_steps];
            exp_pc[run_steps] = pc;
            u = prog[pc[9:1]];
            a = m_regs[u.opr.sr1];
            b = u.opr.imm ? {{11{u.opr.sr2_imm5[4]}}, u.opr.sr2_imm5}
                          : m_regs[u.opr.sr2_imm5[2:0]];
            addr = m_regs[u.mem.base] + {{9{u.mem.offset6[5]}}, u.mem.offset6, 1'b0};
            case (u.opr.opcode)
                lc3b_types::op_add: model_write(u.opr.dr, a + b);
                lc3b_types::op_and: model_write(u.opr.dr, a & b);
                lc3b_types::op_not: model_write(u.opr.dr, ~a);
                lc3b_types::op_shf: begin
                    if (!u.shf.dir) r = a << u.shf.imm4;
                    else if (!u.shf.arith) r = a >> u.shf.imm4;
                    else r = shift_right_arith(a, u.shf.imm4);
                    model_write(u.shf.dr, r);
                end
                lc3b_types::op_ldr: model_write(u.mem.dr_sr, m_mem[addr[8:1]]);
                lc3b_types::op_str: m_mem[addr[8:1]] = m_regs[u.mem.dr_sr];
                lc3b_types::op_br: begin
                    if (|({u.br.n, u.br.z, u.br.p} & m_cc)) begin
                        redir_v[run_steps + 4] = 1'b1;
                        redir_t[run_steps + 4] = pc + 16'd2 +
                            {{6{u.br.offset9[8]}}, u.br.offset9, 1'b0};
                        last_redir = run_steps + 4;
                    end
                end
                default: ; // outside the subset, no effect
            endcase
            pc = pc + 16'd2;
            run_steps++;
        end
    endtask

    task automatic run_prog();
        exp_dest.delete();
        exp_data.delete();
        for (int i = 0; i < 8; i++) begin
            m_regs[i] = '0;
        end
        m_cc = 3'b010;
        @(posedge clk);
        #1 rst_n = 1'b0;
        build_expect();
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int i = 0; i < run_steps; i++) begin
            cmp_word("imem_addr", imem_addr, exp_pc[i]);
            @(posedge clk);
            #1;
        end
        repeat (8) @(posedge clk);
        if (exp_dest.size() != 0) begin
            fail_run($sformatf("%0d expected writebacks never appeared", exp_dest.size()));
        end
    endtask

    always @(negedge clk) begin
        if (rst_n !== 1'b1) begin
            if (wb_load === 1'b1) fail_run("writeback seen while reset is asserted");
        end else if (wb_load === 1'b1) begin
            if (exp_dest.size() == 0) begin
                fail_run("writeback seen when none was expected");
            end else begin
                cmp_dest("wb_dest", wb_dest, exp_dest.pop_front());
                cmp_word("wb_data", wb_data, exp_data.pop_front());
            end
        end
    end

    task automatic test_alu();
        clear_prog();
        emit(enc_opr(lc3b_types::op_add, 1, 0, 1'b1, 5));
        emit(enc_opr(lc3b_types::op_add, 2, 0, 1'b1, -3));
        emit(enc_opr(lc3b_types::op_add, 3, 1, 1'b0, 2));
        emit(enc_opr(lc3b_types::op_and, 4, 1, 1'b0, 2));
        emit(enc_opr(lc3b_types::op_and, 5, 2, 1'b1, 13));
        emit(enc_opr(lc3b_types::op_not, 6, 2, 1'b1, 31));
        emit(enc_opr(lc3b_types::op_add, 7, 3, 1'b1, 15));
        emit(enc_opr(lc3b_types::op_and, 1, 6, 1'b1, -16));
        run_prog();
    endtask

    task automatic test_shifts();
        clear_prog();
        emit(enc_opr(lc3b_types::op_add, 1, 0, 1'b1, -8));
        emit(enc_opr(lc3b_types::op_add, 2, 0, 1'b1, 7));
        for (int k = 0; k < 16; k += 3) begin
            emit(enc_shf(3, 1, 1'b0, 1'b0, k));
            emit(enc_shf(4, 1, 1'b0, 1'b1, k));
            emit(enc_shf(5, 1, 1'b1, 1'b1, k));
            emit(enc_shf(6, 2, 1'b1, 1'b1, k)); // sra of a positive value
        end
        emit(enc_shf(7, 2, 1'b0, 1'b0, 15));
        run_prog();
    endtask

    task automatic test_memory();
        clear_prog();
        emit(enc_opr(lc3b_types::op_add, 1, 0, 1'b1, 15));
        emit(enc_opr(lc3b_types::op_add, 1, 1, 1'b1, 5));
        emit(enc_opr(lc3b_types::op_add, 2, 0, 1'b1, 12));
        emit(enc_shf(2, 2, 1'b0, 1'b0, 3));
        emit(enc_opr(lc3b_types::op_add, 3, 0, 1'b1, -7));
        emit(enc_mem(lc3b_types::op_str, 3, 1, 3));
        emit(enc_mem(lc3b_types::op_str, 2, 2, -4));
        emit(enc_mem(lc3b_types::op_str, 1, 1, -2));
        emit(enc_mem(lc3b_types::op_ldr, 4, 1, 3));
        emit(enc_mem(lc3b_types::op_ldr, 5, 2, -4));
        emit(enc_mem(lc3b_types::op_ldr, 6, 1, -2));
        run_prog();
    endtask

    task automatic test_branches();
        clear_prog();
        emit(enc_opr(lc3b_types::op_add, 5, 0, 1'b1, -5));
        emit(enc_mem(lc3b_types::op_str, 5, 0, 10));
        for (int p = 0; p < 4; p++) begin
            for (int m = 0; m < 8; m++) begin
                case (p)
                    0: emit(enc_opr(lc3b_types::op_add, 1, 0, 1'b1, -2));
                    1: emit(enc_opr(lc3b_types::op_add, 1, 0, 1'b1, 0));
                    2: emit(enc_opr(lc3b_types::op_add, 1, 0, 1'b1, 3));
                    default: emit(enc_mem(lc3b_types::op_ldr, 1, 0, 10));
                endcase
                emit(enc_br(3'(m), 8));                        // lands after the skip word
                emit(enc_opr(lc3b_types::op_add, 2, 0, 1'b1, m)); // last delay slot
                emit(enc_opr(lc3b_types::op_add, 3, 0, 1'b1, p)); // skipped when taken
            end
        end
        run_prog();
    endtask

    task automatic test_random();
        int unsigned kind;
        int unsigned d;
        int unsigned s1;
        int unsigned s2;
        int unsigned v;
        clear_prog();
        emit(enc_opr(lc3b_types::op_add, 7, 0, 1'b1, 8));
        emit(enc_shf(7, 7, 1'b0, 1'b0, 2)); // r7 is the data base
        for (int s = 0; s < 8; s++) begin
            emit(enc_mem(lc3b_types::op_str, 0, 7, s));
        end
        for (int n = 0; n < 60; n++) begin
            kind = lcg_next() % 7;
            d = lcg_next() % 7;
            s1 = lcg_next() % 8;
            s2 = lcg_next() % 8;
            v = lcg_next();
            case (kind)
                0: emit(enc_opr(lc3b_types::op_add, d, s1, 1'b0, s2));
                1: emit(enc_opr(lc3b_types::op_add, d, s1, 1'b1, v));
                2: emit(enc_opr(lc3b_types::op_and, d, s1, 1'b0, s2));
                3: emit(enc_opr(lc3b_types::op_and, d, s1, 1'b1, v));
                4: emit(enc_opr(lc3b_types::op_not, d, s1, 1'b1, 31));
                5: emit(enc_shf(d, s1, v[5], v[4], v[3:0]));
                default: begin
                    if (v[0]) emit(enc_mem(lc3b_types::op_ldr, d, 7, s2));
                    else emit(enc_mem(lc3b_types::op_str, s1, 7, s2));
                end
            endcase
        end
        run_prog();
    endtask

    task automatic test_unknown();
        clear_prog();
        emit(enc_opr(lc3b_types::op_add, 1, 0, 1'b1, 4));
        emit(16'hf0a5);
        emit(16'h2abc);
        emit(16'hc1c0);
        emit(enc_opr(lc3b_types::op_add, 2, 1, 1'b1, 3));
        emit(16'he5a5);
        emit(enc_opr(lc3b_types::op_not, 3, 2, 1'b1, 31));
        run_prog();
    endtask

    initial begin
        rst_n = 1'b0;
        imem_rdata = '0;
        lcg_state = 75585;
        clear_prog();
        test_unknown(); // first, so reset from power-up is covered too
        test_alu();
        test_shifts();
        test_memory();
        test_branches();
        test_random();
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        #(watchdog_cycles * 8);
        fail_run("watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/lc3b_types.sv
rtl/lc3b_ctrl_pkg.sv
rtl/control_rom.sv
rtl/regfile.sv
rtl/alu.sv
rtl/data_memory.sv
rtl/lc3b_pipeline.sv
tb/lc3b_pipeline_checker.sv
tb/lc3b_pipeline_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the lc3b pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f \
    --top-module lc3b_pipeline_tb -o sim_lc3b
status=$?
if [ $status -ne 0 ]; then
    echo "build failed"
    exit $status
fi

./obj_dir/sim_lc3b
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0
